//--- src/mem_pkg.sv
/* Response codes, master IDs and the traffic data pattern shared by the
   memory subsystem RTL. Compile ahead of every module that names it. */
`default_nettype none

package mem_pkg;

   typedef logic [1:0] axi_resp_t;
   typedef logic [3:0] axi_id_t;

   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

   // Fixed master IDs, echoed on bid and rid
   localparam axi_id_t HOST_ID = 4'h1;
   localparam axi_id_t TG_ID   = 4'h2;

   // Traffic data is the word address XOR this
   localparam logic [31:0] TG_PATTERN = 32'hC3A5_5A96;

endpackage

`default_nettype wire

//--- src/axi_mem_mux.sv
/* Two-to-one AXI-MM steering toward the external memory, chosen by sel.
   sel low passes the host port (s0), high the traffic generator (s1).
   Purely combinational; clk and rst only clock the assertions. */
`timescale 1ns/100ps
`default_nettype none

module axi_mem_mux #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 32
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      sel,
   // Source 0, host port
   input  logic                      s0_awvalid, s0_wvalid, s0_wlast, s0_bready,
   input  logic                      s0_arvalid, s0_rready,
   input  mem_pkg::axi_id_t          s0_awid, s0_arid,
   input  logic [ADDR_W-1:0]         s0_awaddr, s0_araddr,
   input  logic [DATA_W-1:0]         s0_wdata,
   input  logic [DATA_W/8-1:0]       s0_wstrb,
   output logic                      s0_awready, s0_wready, s0_bvalid,
   output logic                      s0_arready, s0_rvalid, s0_rlast,
   output mem_pkg::axi_id_t          s0_bid, s0_rid,
   output mem_pkg::axi_resp_t        s0_bresp, s0_rresp,
   output logic [DATA_W-1:0]         s0_rdata,
   // Source 1, traffic generator
   input  logic                      s1_awvalid, s1_wvalid, s1_wlast, s1_bready,
   input  logic                      s1_arvalid, s1_rready,
   input  mem_pkg::axi_id_t          s1_awid, s1_arid,
   input  logic [ADDR_W-1:0]         s1_awaddr, s1_araddr,
   input  logic [DATA_W-1:0]         s1_wdata,
   input  logic [DATA_W/8-1:0]       s1_wstrb,
   output logic                      s1_awready, s1_wready, s1_bvalid,
   output logic                      s1_arready, s1_rvalid, s1_rlast,
   output mem_pkg::axi_id_t          s1_bid, s1_rid,
   output mem_pkg::axi_resp_t        s1_bresp, s1_rresp,
   output logic [DATA_W-1:0]         s1_rdata,
   // Toward the memory
   output logic                      m_awvalid, m_wvalid, m_wlast, m_bready,
   output logic                      m_arvalid, m_rready,
   output mem_pkg::axi_id_t          m_awid, m_arid,
   output logic [ADDR_W-1:0]         m_awaddr, m_araddr,
   output logic [DATA_W-1:0]         m_wdata,
   output logic [DATA_W/8-1:0]       m_wstrb,
   input  logic                      m_awready, m_wready, m_bvalid,
   input  logic                      m_arready, m_rvalid, m_rlast,
   input  mem_pkg::axi_id_t          m_bid, m_rid,
   input  mem_pkg::axi_resp_t        m_bresp, m_rresp,
   input  logic [DATA_W-1:0]         m_rdata
);

   // --------------------
   // Requests from the selected source
   assign m_awvalid = sel ? s1_awvalid : s0_awvalid;
   assign m_awid    = sel ? s1_awid    : s0_awid;
   assign m_awaddr  = sel ? s1_awaddr  : s0_awaddr;
   assign m_wvalid  = sel ? s1_wvalid  : s0_wvalid;
   assign m_wdata   = sel ? s1_wdata   : s0_wdata;
   assign m_wstrb   = sel ? s1_wstrb   : s0_wstrb;
   assign m_wlast   = sel ? s1_wlast   : s0_wlast;
   assign m_bready  = sel ? s1_bready  : s0_bready;
   assign m_arvalid = sel ? s1_arvalid : s0_arvalid;
   assign m_arid    = sel ? s1_arid    : s0_arid;
   assign m_araddr  = sel ? s1_araddr  : s0_araddr;
   assign m_rready  = sel ? s1_rready  : s0_rready;

   // --------------------
   // Ready and responses, zero toward the idle side
   assign s0_awready = !sel ? m_awready : 1'b0;
   assign s0_wready  = !sel ? m_wready  : 1'b0;
   assign s0_bvalid  = !sel ? m_bvalid  : 1'b0;
   assign s0_bid     = !sel ? m_bid     : '0;
   assign s0_bresp   = !sel ? m_bresp   : '0;
   assign s0_arready = !sel ? m_arready : 1'b0;
   assign s0_rvalid  = !sel ? m_rvalid  : 1'b0;
   assign s0_rid     = !sel ? m_rid     : '0;
   assign s0_rdata   = !sel ? m_rdata   : '0;
   assign s0_rresp   = !sel ? m_rresp   : '0;
   assign s0_rlast   = !sel ? m_rlast   : 1'b0;

   assign s1_awready = sel ? m_awready : 1'b0;
   assign s1_wready  = sel ? m_wready  : 1'b0;
   assign s1_bvalid  = sel ? m_bvalid  : 1'b0;
   assign s1_bid     = sel ? m_bid     : '0;
   assign s1_bresp   = sel ? m_bresp   : '0;
   assign s1_arready = sel ? m_arready : 1'b0;
   assign s1_rvalid  = sel ? m_rvalid  : 1'b0;
   assign s1_rid     = sel ? m_rid     : '0;
   assign s1_rdata   = sel ? m_rdata   : '0;
   assign s1_rresp   = sel ? m_rresp   : '0;
   assign s1_rlast   = sel ? m_rlast   : 1'b0;

   // --------------------
   logic any_vld;

   assign any_vld = s0_awvalid | s0_wvalid | s0_arvalid | s1_awvalid | s1_wvalid | s1_arvalid
                  | m_bvalid | m_rvalid;

   // Switching is only legal with the whole path quiet
   a_sel_quiet: assert property (@(posedge clk) disable iff (rst)
      $changed(sel) |-> !any_vld && !$past(any_vld));

   // The idle side raises no request, so it never waits on a ready it cannot see
   a_idle_side: assert property (@(posedge clk) disable iff (rst)
      (sel ? (s0_awvalid | s0_wvalid | s0_arvalid)
           : (s1_awvalid | s1_wvalid | s1_arvalid)) == 1'b0);

endmodule

`default_nettype wire

//--- src/mem_host_port.sv
/* Host access port. Each cmd_valid strobe becomes one single-beat AXI
   write or read; the result comes back as a one-cycle rsp_valid pulse. */
`timescale 1ns/100ps
`default_nettype none

module mem_host_port #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 32
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      cmd_valid,
   input  logic                      cmd_write,
   input  logic [ADDR_W-1:0]         cmd_addr,
   input  logic [DATA_W-1:0]         cmd_wdata,
   output logic                      rsp_valid,
   output logic [DATA_W-1:0]         rsp_rdata,
   output logic                      rsp_err,
   output logic                      busy,
   // AXI master
   output logic                      s0_awvalid, s0_wvalid, s0_wlast, s0_bready,
   output logic                      s0_arvalid, s0_rready,
   output mem_pkg::axi_id_t          s0_awid, s0_arid,
   output logic [ADDR_W-1:0]         s0_awaddr, s0_araddr,
   output logic [DATA_W-1:0]         s0_wdata,
   output logic [DATA_W/8-1:0]       s0_wstrb,
   input  logic                      s0_awready, s0_wready, s0_bvalid,
   input  logic                      s0_arready, s0_rvalid, s0_rlast,
   input  mem_pkg::axi_id_t          s0_bid, s0_rid,
   input  mem_pkg::axi_resp_t        s0_bresp, s0_rresp,
   input  logic [DATA_W-1:0]         s0_rdata
);

   import mem_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RESP} state_t;

   state_t            state;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic              req_done;
   logic              b_mine;
   logic              r_mine;

   assign s0_awid   = HOST_ID;
   assign s0_arid   = HOST_ID;
   assign s0_awaddr = addr_q;
   assign s0_araddr = addr_q;
   assign s0_wdata  = wdata_q;
   assign s0_wstrb  = '1;
   assign s0_wlast  = 1'b1;
   assign s0_bready = 1'b1;
   assign s0_rready = 1'b1;
   assign busy      = (state != ST_IDLE);

   // Every raised valid transfers in this cycle or already has
   assign req_done = (!s0_awvalid || s0_awready) && (!s0_wvalid || s0_wready)
                   && (!s0_arvalid || s0_arready);
   assign b_mine   = s0_bvalid && (s0_bid == HOST_ID);
   assign r_mine   = s0_rvalid && s0_rlast && (s0_rid == HOST_ID);

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= ST_IDLE;
         s0_awvalid <= 1'b0;
         s0_wvalid  <= 1'b0;
         s0_arvalid <= 1'b0;
         rsp_valid  <= 1'b0;
      end else begin
         rsp_valid <= 1'b0;
         case (state)
            ST_IDLE: if (cmd_valid) begin
               addr_q     <= cmd_addr;
               wdata_q    <= cmd_wdata;
               s0_awvalid <= cmd_write;
               s0_wvalid  <= cmd_write;
               s0_arvalid <= !cmd_write;
               state      <= ST_REQ;
            end
            ST_REQ: begin
               if (s0_awready) s0_awvalid <= 1'b0;
               if (s0_wready)  s0_wvalid  <= 1'b0;
               if (s0_arready) s0_arvalid <= 1'b0;
               if (req_done)   state      <= ST_RESP;
            end
            default: if (b_mine || r_mine) begin
               rsp_valid <= 1'b1;
               rsp_rdata <= r_mine ? s0_rdata : '0;
               rsp_err   <= r_mine ? (s0_rresp != RESP_OKAY) : (s0_bresp != RESP_OKAY);
               state     <= ST_IDLE;
            end
         endcase
      end
   end

   a_rsp_open: assert property (@(posedge clk) disable iff (rst)
      (s0_bvalid || s0_rvalid) |-> state != ST_IDLE);

endmodule

`default_nettype wire

//--- src/mem_traffic_gen.sv
/* Memory exerciser. A tg_start strobe writes a pattern to tg_count words
   from tg_base, reads them back one at a time and counts bad reads. */
`timescale 1ns/100ps
`default_nettype none

module mem_traffic_gen #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 32
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      tg_start,
   input  logic [ADDR_W-1:0]         tg_base,
   input  logic [ADDR_W:0]           tg_count,
   output logic                      tg_done,
   output logic [ADDR_W:0]           tg_err_count,
   output logic                      tg_busy,
   // AXI master
   output logic                      s1_awvalid, s1_wvalid, s1_wlast, s1_bready,
   output logic                      s1_arvalid, s1_rready,
   output mem_pkg::axi_id_t          s1_awid, s1_arid,
   output logic [ADDR_W-1:0]         s1_awaddr, s1_araddr,
   output logic [DATA_W-1:0]         s1_wdata,
   output logic [DATA_W/8-1:0]       s1_wstrb,
   input  logic                      s1_awready, s1_wready, s1_bvalid,
   input  logic                      s1_arready, s1_rvalid, s1_rlast,
   input  mem_pkg::axi_id_t          s1_bid, s1_rid,
   input  mem_pkg::axi_resp_t        s1_bresp, s1_rresp,
   input  logic [DATA_W-1:0]         s1_rdata
);

   import mem_pkg::*;

   typedef enum logic [2:0] {ST_IDLE, ST_WR_REQ, ST_WR_RESP, ST_RD_REQ, ST_RD_RESP} state_t;

   state_t            state;
   logic [ADDR_W-1:0] base_q;
   logic [ADDR_W-1:0] addr_q;
   logic [ADDR_W:0]   count_q;
   logic [ADDR_W:0]   left_q;
   logic [DATA_W-1:0] pattern;
   logic              last_word;
   logic              bad_read;

   assign pattern    = DATA_W'(TG_PATTERN) ^ DATA_W'(addr_q);
   assign last_word  = (left_q == 1);
   // Wrong data and error response count once together
   assign bad_read   = (s1_rdata != pattern) || (s1_rresp != RESP_OKAY);

   assign s1_awid    = TG_ID;
   assign s1_arid    = TG_ID;
   assign s1_awaddr  = addr_q;
   assign s1_araddr  = addr_q;
   assign s1_wdata   = pattern;
   assign s1_wstrb   = '1;
   assign s1_wlast   = 1'b1;
   assign s1_bready  = 1'b1;
   assign s1_rready  = 1'b1;
   assign tg_busy    = (state != ST_IDLE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= ST_IDLE;
         s1_awvalid   <= 1'b0;
         s1_wvalid    <= 1'b0;
         s1_arvalid   <= 1'b0;
         tg_done      <= 1'b0;
         tg_err_count <= '0;
      end else begin
         tg_done <= 1'b0;
         case (state)
            ST_IDLE: if (tg_start) begin
               base_q       <= tg_base;
               addr_q       <= tg_base;
               count_q      <= tg_count;
               left_q       <= tg_count;
               tg_err_count <= '0;
               s1_awvalid   <= 1'b1;
               s1_wvalid    <= 1'b1;
               state        <= ST_WR_REQ;
            end
            ST_WR_REQ: begin
               if (s1_awready) s1_awvalid <= 1'b0;
               if (s1_wready)  s1_wvalid  <= 1'b0;
               if ((!s1_awvalid || s1_awready) && (!s1_wvalid || s1_wready)) begin
                  state <= ST_WR_RESP;
               end
            end
            ST_WR_RESP: if (s1_bvalid && s1_bid == TG_ID) begin
               if (last_word) begin
                  // Write phase over, restart from the base for readback
                  addr_q     <= base_q;
                  left_q     <= count_q;
                  s1_arvalid <= 1'b1;
                  state      <= ST_RD_REQ;
               end else begin
                  addr_q     <= addr_q + 1'b1;
                  left_q     <= left_q - 1'b1;
                  s1_awvalid <= 1'b1;
                  s1_wvalid  <= 1'b1;
                  state      <= ST_WR_REQ;
               end
            end
            ST_RD_REQ: if (s1_arready) begin
               s1_arvalid <= 1'b0;
               state      <= ST_RD_RESP;
            end
            default: if (s1_rvalid && s1_rlast && s1_rid == TG_ID) begin
               if (bad_read) tg_err_count <= tg_err_count + 1'b1;
               if (last_word) begin
                  tg_done <= 1'b1;
                  state   <= ST_IDLE;
               end else begin
                  addr_q     <= addr_q + 1'b1;
                  left_q     <= left_q - 1'b1;
                  s1_arvalid <= 1'b1;
                  state      <= ST_RD_REQ;
               end
            end
         endcase
      end
   end

   a_count_nz: assert property (@(posedge clk) disable iff (rst)
      (tg_start && !tg_busy) |-> tg_count != '0);

endmodule

`default_nettype wire

//--- src/axi_mem_model.sv
/* AXI-MM slave holding a word RAM, standing in for the external memory.
   Single-beat only. Addresses at or past MEM_WORDS answer SLVERR. */
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model #(
   parameter int ADDR_W    = 10,
   parameter int DATA_W    = 32,
   parameter int MEM_WORDS = 256
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      m_awvalid, m_wvalid, m_wlast, m_bready,
   input  logic                      m_arvalid, m_rready,
   input  mem_pkg::axi_id_t          m_awid, m_arid,
   input  logic [ADDR_W-1:0]         m_awaddr, m_araddr,
   input  logic [DATA_W-1:0]         m_wdata,
   input  logic [DATA_W/8-1:0]       m_wstrb,
   output logic                      m_awready, m_wready, m_bvalid,
   output logic                      m_arready, m_rvalid, m_rlast,
   output mem_pkg::axi_id_t          m_bid, m_rid,
   output mem_pkg::axi_resp_t        m_bresp, m_rresp,
   output logic [DATA_W-1:0]         m_rdata
);

   import mem_pkg::*;

   localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   logic [DATA_W-1:0] ram [MEM_WORDS];
   logic              wr_take;
   logic              rd_take;
   logic              wr_hit;
   logic              rd_hit;

   // A pending response blocks its own request channel
   assign m_awready = !m_bvalid;
   assign m_wready  = !m_bvalid;
   assign m_arready = !m_rvalid;
   assign m_rlast   = m_rvalid;

   assign wr_take = m_awvalid && m_wvalid && !m_bvalid;
   assign rd_take = m_arvalid && !m_rvalid;
   assign wr_hit  = int'(m_awaddr) < MEM_WORDS;
   assign rd_hit  = int'(m_araddr) < MEM_WORDS;

   always_ff @(posedge clk) begin
      if (wr_take && wr_hit) begin
         for (int b = 0; b < DATA_W/8; b++) begin
            if (m_wstrb[b]) ram[m_awaddr[IDX_W-1:0]][b*8 +: 8] <= m_wdata[b*8 +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         m_bvalid <= 1'b0;
         m_rvalid <= 1'b0;
      end else begin
         if (wr_take) m_bvalid <= 1'b1;
         else if (m_bready) m_bvalid <= 1'b0;
         if (rd_take) m_rvalid <= 1'b1;
         else if (m_rready) m_rvalid <= 1'b0;
      end
   end

   // Response payload, ID echoed from the request
   always_ff @(posedge clk) begin
      if (wr_take) begin
         m_bid   <= m_awid;
         m_bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      end
      if (rd_take) begin
         m_rid   <= m_arid;
         m_rdata <= rd_hit ? ram[m_araddr[IDX_W-1:0]] : '0;
         m_rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      end
   end

   a_wlast: assert property (@(posedge clk) disable iff (rst)
      wr_take |-> m_wlast);

endmodule

`default_nettype wire

//--- src/mem_subsystem_top.sv
/* Memory subsystem top. The host port and the traffic generator share one
   memory model through the sel-driven mux. Instances and wires only. */
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem_top #(
   parameter int ADDR_W    = 10,
   parameter int DATA_W    = 32,
   parameter int MEM_WORDS = 256
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      sel,
   // Host commands
   input  logic                      cmd_valid,
   input  logic                      cmd_write,
   input  logic [ADDR_W-1:0]         cmd_addr,
   input  logic [DATA_W-1:0]         cmd_wdata,
   output logic                      rsp_valid,
   output logic [DATA_W-1:0]         rsp_rdata,
   output logic                      rsp_err,
   output logic                      busy,
   // Traffic runs
   input  logic                      tg_start,
   input  logic [ADDR_W-1:0]         tg_base,
   input  logic [ADDR_W:0]           tg_count,
   output logic                      tg_done,
   output logic [ADDR_W:0]           tg_err_count,
   output logic                      tg_busy
);

   import mem_pkg::*;

   // --------------------
   // Host port to mux
   logic                s0_awvalid, s0_wvalid, s0_wlast, s0_bready, s0_arvalid, s0_rready;
   logic                s0_awready, s0_wready, s0_bvalid, s0_arready, s0_rvalid, s0_rlast;
   axi_id_t             s0_awid, s0_arid, s0_bid, s0_rid;
   axi_resp_t           s0_bresp, s0_rresp;
   logic [ADDR_W-1:0]   s0_awaddr, s0_araddr;
   logic [DATA_W-1:0]   s0_wdata, s0_rdata;
   logic [DATA_W/8-1:0] s0_wstrb;

   // Traffic generator to mux
   logic                s1_awvalid, s1_wvalid, s1_wlast, s1_bready, s1_arvalid, s1_rready;
   logic                s1_awready, s1_wready, s1_bvalid, s1_arready, s1_rvalid, s1_rlast;
   axi_id_t             s1_awid, s1_arid, s1_bid, s1_rid;
   axi_resp_t           s1_bresp, s1_rresp;
   logic [ADDR_W-1:0]   s1_awaddr, s1_araddr;
   logic [DATA_W-1:0]   s1_wdata, s1_rdata;
   logic [DATA_W/8-1:0] s1_wstrb;

   // Mux to memory
   logic                m_awvalid, m_wvalid, m_wlast, m_bready, m_arvalid, m_rready;
   logic                m_awready, m_wready, m_bvalid, m_arready, m_rvalid, m_rlast;
   axi_id_t             m_awid, m_arid, m_bid, m_rid;
   axi_resp_t           m_bresp, m_rresp;
   logic [ADDR_W-1:0]   m_awaddr, m_araddr;
   logic [DATA_W-1:0]   m_wdata, m_rdata;
   logic [DATA_W/8-1:0] m_wstrb;

   // --------------------
   mem_host_port #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_mem_host_port (.*);

   mem_traffic_gen #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_mem_traffic_gen (.*);

   axi_mem_mux #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_axi_mem_mux (.*);

   axi_mem_model #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .MEM_WORDS (MEM_WORDS)
   ) i_axi_mem_model (.*);

endmodule

`default_nettype wire

//--- verif/mem_checker.sv
/* Result checker for the memory subsystem testbench. Compares each host
   response and traffic result with the expected values of the current row
   and prints one line per finished test. */
`timescale 1ns/100ps
`default_nettype none

module mem_checker #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              idle_check,
   input  int                row_idx,
   input  logic              is_read,
   input  logic              is_traffic,
   input  logic [DATA_W-1:0] exp_data,
   input  logic              exp_err,
   input  logic [ADDR_W:0]   exp_count,
   input  logic              rsp_valid,
   input  logic [DATA_W-1:0] rsp_rdata,
   input  logic              rsp_err,
   input  logic              busy,
   input  logic              tg_done,
   input  logic [ADDR_W:0]   tg_err_count,
   input  logic              tg_busy,
   output int                tests_run,
   output int                tests_failed
);

   int n_run = 0;
   int n_failed = 0;
   int mismatches = 0;

   assign tests_run    = n_run;
   assign tests_failed = n_failed;

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] want);
      if (got !== want) begin
         $display("error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
         mismatches++;
      end
   endtask

   task automatic close_test(input string what);
      n_run++;
      if (mismatches == 0) begin
         $display("test %0d %s: ok", row_idx, what);
      end else begin
         n_failed++;
         $display("test %0d %s: failed", row_idx, what);
      end
   endtask

   // Outputs are registered, so the pre-edge values are sampled here
   always @(posedge clk) begin
      if (idle_check) begin
         mismatches = 0;
         compare_value("busy", 64'(busy), 64'(0));
         compare_value("tg_busy", 64'(tg_busy), 64'(0));
         compare_value("rsp_valid", 64'(rsp_valid), 64'(0));
         compare_value("tg_done", 64'(tg_done), 64'(0));
         compare_value("tg_err_count", 64'(tg_err_count), 64'(0));
         close_test("reset state");
      end
      if (rsp_valid) begin
         mismatches = 0;
         if (is_traffic) begin
            $display("row %0d: a host response arrived during a traffic run", row_idx);
            mismatches++;
         end else begin
            compare_value("rsp_err", 64'(rsp_err), 64'(exp_err));
            if (is_read) compare_value("rsp_rdata", 64'(rsp_rdata), 64'(exp_data));
         end
         if (is_read) close_test("host read");
         else close_test("host write");
      end
      if (tg_done) begin
         mismatches = 0;
         if (!is_traffic) begin
            $display("row %0d: tg_done pulsed during a host command", row_idx);
            mismatches++;
         end else begin
            compare_value("tg_err_count", 64'(tg_err_count), 64'(exp_count));
         end
         close_test("traffic run");
      end
   end

endmodule

`default_nettype wire

//--- verif/tb_mem_subsystem.sv
/* Testbench for the memory subsystem. Builds a table of host and traffic
   operations with their expected results, applies it row by row on the
   falling clock edge and leaves the comparing to mem_checker. */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsystem;

   import mem_pkg::*;

   localparam int ADDR_W    = 10;
   localparam int DATA_W    = 32;
   localparam int MEM_WORDS = 256;
   localparam int MAX_ROWS  = 24;
   localparam int KIND_WR   = 0;
   localparam int KIND_RD   = 1;
   localparam int KIND_TG   = 2;

   logic                clk;
   logic                rst;
   logic                sel;
   logic                cmd_valid;
   logic                cmd_write;
   logic [ADDR_W-1:0]   cmd_addr;
   logic [DATA_W-1:0]   cmd_wdata;
   logic                rsp_valid;
   logic [DATA_W-1:0]   rsp_rdata;
   logic                rsp_err;
   logic                busy;
   logic                tg_start;
   logic [ADDR_W-1:0]   tg_base;
   logic [ADDR_W:0]     tg_count;
   logic                tg_done;
   logic [ADDR_W:0]     tg_err_count;
   logic                tg_busy;

   // Expectations of the row in flight
   logic                idle_check;
   int                  row_idx;
   logic                is_read;
   logic                is_traffic;
   logic [DATA_W-1:0]   exp_data;
   logic                exp_err;
   logic [ADDR_W:0]     exp_count;
   int                  tests_run;
   int                  tests_failed;

   // --------------------
   // Stimulus table
   int                  n_rows;
   int                  tbl_kind      [MAX_ROWS];
   logic                tbl_sel       [MAX_ROWS];
   int                  tbl_addr      [MAX_ROWS];
   logic [DATA_W-1:0]   tbl_data      [MAX_ROWS];
   logic [DATA_W-1:0]   tbl_exp_data  [MAX_ROWS];
   logic                tbl_exp_err   [MAX_ROWS];
   int                  tbl_exp_count [MAX_ROWS];
   logic [DATA_W-1:0]   shadow        [int];
   logic [31:0]         lfsr_state;
   int                  limit_cycles;
   logic                table_ready;

   mem_subsystem_top #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .MEM_WORDS (MEM_WORDS)
   ) i_mem_subsystem_top (.*);

   mem_checker #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_mem_checker (.*);

   always #50 clk = ~clk;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic random_word(output logic [DATA_W-1:0] w);
      w = '0;
      for (int b = 0; b < DATA_W; b++) begin
         lfsr_state = lfsr_next(lfsr_state);
         w = {w[DATA_W-2:0], lfsr_state[0]};
      end
   endtask

   // Appends one row; expected values follow from earlier rows
   task automatic add_row(input int kind, input int addr, input int count);
      logic [DATA_W-1:0] wdata;
      int                n_bad;
      tbl_kind[n_rows]      = kind;
      tbl_sel[n_rows]       = (kind == KIND_TG);
      tbl_addr[n_rows]      = addr;
      tbl_data[n_rows]      = '0;
      tbl_exp_data[n_rows]  = '0;
      tbl_exp_err[n_rows]   = (addr >= MEM_WORDS);
      tbl_exp_count[n_rows] = 0;
      limit_cycles += 16;
      if (kind == KIND_WR) begin
         random_word(wdata);
         tbl_data[n_rows] = wdata;
         if (addr < MEM_WORDS) shadow[addr] = wdata;
      end else if (kind == KIND_RD) begin
         if (addr < MEM_WORDS) tbl_exp_data[n_rows] = shadow[addr];
      end else begin
         n_bad = 0;
         tbl_data[n_rows] = DATA_W'(count);
         for (int a = addr; a < addr + count; a++) begin
            if (a >= MEM_WORDS) n_bad++;
            else shadow[a] = DATA_W'(TG_PATTERN) ^ DATA_W'(a);
         end
         tbl_exp_count[n_rows] = n_bad;
         limit_cycles += 8 * count;
      end
      n_rows++;
   endtask

   task automatic build_table();
      add_row(KIND_WR, 5, 0);
      add_row(KIND_WR, 17, 0);
      add_row(KIND_WR, 100, 0);
      add_row(KIND_WR, 200, 0);
      add_row(KIND_RD, 5, 0);
      add_row(KIND_RD, 17, 0);
      add_row(KIND_RD, 100, 0);
      add_row(KIND_RD, 200, 0);
      // Past the end of the RAM
      add_row(KIND_WR, 300, 0);
      add_row(KIND_RD, 700, 0);
      add_row(KIND_TG, 32, 16);
      add_row(KIND_TG, 250, 10);
      // Back on the host after the traffic runs
      add_row(KIND_RD, 32, 0);
      add_row(KIND_RD, 47, 0);
      add_row(KIND_RD, 252, 0);
      add_row(KIND_RD, 5, 0);
      add_row(KIND_RD, 100, 0);
   endtask

   task automatic run_row(input int i);
      row_idx    = i + 1;
      is_read    = (tbl_kind[i] == KIND_RD);
      is_traffic = (tbl_kind[i] == KIND_TG);
      exp_data   = tbl_exp_data[i];
      exp_err    = tbl_exp_err[i];
      exp_count  = (ADDR_W+1)'(tbl_exp_count[i]);
      sel        = tbl_sel[i];
      if (tbl_kind[i] == KIND_TG) begin
         tg_base  = ADDR_W'(tbl_addr[i]);
         tg_count = (ADDR_W+1)'(tbl_data[i]);
         tg_start = 1'b1;
      end else begin
         cmd_write = (tbl_kind[i] == KIND_WR);
         cmd_addr  = ADDR_W'(tbl_addr[i]);
         cmd_wdata = tbl_data[i];
         cmd_valid = 1'b1;
      end
      @(negedge clk);
      cmd_valid = 1'b0;
      tg_start  = 1'b0;
      while (!(rsp_valid || tg_done)) @(negedge clk);
      // Hold the row until the checker has sampled the result
      @(negedge clk);
   endtask

   // --------------------
   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      sel          = 1'b0;
      cmd_valid    = 1'b0;
      cmd_write    = 1'b0;
      cmd_addr     = '0;
      cmd_wdata    = '0;
      tg_start     = 1'b0;
      tg_base      = '0;
      tg_count     = '0;
      idle_check   = 1'b0;
      row_idx      = 0;
      is_read      = 1'b0;
      is_traffic   = 1'b0;
      exp_data     = '0;
      exp_err      = 1'b0;
      exp_count    = '0;
      n_rows       = 0;
      lfsr_state   = 32'h576e83aa;
      limit_cycles = 40;
      table_ready  = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      idle_check = 1'b1;
      @(negedge clk);
      idle_check = 1'b0;
      for (int i = 0; i < n_rows; i++) begin
         run_row(i);
      end
      @(negedge clk);
      $display("tests run %0d, failed %0d", tests_run, tests_failed);
      if (tests_run != n_rows + 1) begin
         $display("checker saw %0d results for %0d tests", tests_run, n_rows + 1);
      end
      if (tests_failed == 0 && tests_run == n_rows + 1) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      wait (table_ready);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: no result after %0d cycles at row %0d", limit_cycles, row_idx);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
src/mem_pkg.sv
src/axi_mem_mux.sv
src/mem_host_port.sv
src/mem_traffic_gen.sv
src/axi_mem_model.sv
src/mem_subsystem_top.sv
verif/mem_checker.sv
verif/tb_mem_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_mem_subsystem -o tb_sim \
   && ./obj_dir/tb_sim | tee sim.log \
   && grep -q "Testbench passed" sim.log \
   && echo "simulation run passed" \
   || { echo "simulation run failed"; exit 1; }
